//--- common/uart_config.svh
/*
 * UART peripheral configuration.
 * Bus widths and the address bits that select a register.
 */

`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// Register bus.
`define UART_ADDR_WIDTH 8
`define UART_DATA_WIDTH 32
`define UART_BE_WIDTH   4

// Word aligned registers at 0x0, 0x4, 0x8 and 0xC.
`define UART_REG_LSB 2
`define UART_REG_MSB 3

`endif

//--- common/uart_reg_pkg.sv
/*
 * UART register map types.
 * Bus vectors, register index and the layout of each register.
 */

`default_nettype none

`include "uart_config.svh"

package uart_reg_pkg;

    typedef logic [`UART_ADDR_WIDTH-1:0] uart_addr_t;
    typedef logic [`UART_DATA_WIDTH-1:0] uart_word_t;
    typedef logic [`UART_BE_WIDTH-1:0]   uart_be_t;

    typedef enum logic [`UART_REG_MSB-`UART_REG_LSB:0] {
        CTRL_0  = 2'h0,
        CTRL_1  = 2'h1,
        DATA_TX = 2'h2,
        DATA_RX = 2'h3
    } uart_reg_t;

    // Baud divisor in clock cycles per bit.
    typedef struct packed {
        logic [31:0] baud;
    } uart_ctrl_0_t;

    typedef struct packed {
        logic [30:0] rsvd;
        logic        enable;
    } uart_ctrl_1_t;

    typedef struct packed {
        logic [22:0] rsvd;
        logic        tx_flag;
        logic [7:0]  tx_data;
    } uart_data_tx_t;

    typedef struct packed {
        logic [22:0] rsvd;
        logic        rx_flag;
        logic [7:0]  rx_data;
    } uart_data_rx_t;

endpackage

`default_nettype wire

//--- common/uart_link_pkg.sv
/*
 * UART serial link types.
 * Payload, baud and bit counters, and the engine state machines.
 */

`default_nettype none

package uart_link_pkg;

    typedef logic [7:0]  uart_byte_t;
    typedef logic [31:0] baud_div_t;
    typedef logic [2:0]  bit_idx_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    // HOLD waits for the line to return high after a bad stop bit.
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_HOLD
    } rx_state_t;

endpackage

`default_nettype wire

//--- uart/uart_tx.sv
/*
 * UART transmitter.
 * Sends each accepted byte as an 8N1 frame, LSB first.
 */

`default_nettype none

module uart_tx
    import uart_link_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  baud_div_t  baud_div_i,

    input  uart_byte_t in_data_i,
    input  logic       in_valid_i,
    output logic       in_ready_o,

    output logic       tx_o
);

    tx_state_t  state;
    baud_div_t  cycle_cnt;
    bit_idx_t   bit_idx;
    uart_byte_t shift_q;
    logic       bit_end;

    // Not ready while held in reset.
    assign in_ready_o = rst_n_i && (state == TX_IDLE);
    assign bit_end    = (cycle_cnt == baud_div_i - 1'b1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= TX_IDLE;
            cycle_cnt <= '0;
            bit_idx   <= '0;
            tx_o      <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (in_valid_i) begin
                        tx_o      <= 1'b0;
                        cycle_cnt <= '0;
                        state     <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        cycle_cnt <= '0;
                        bit_idx   <= '0;
                        tx_o      <= shift_q[0];
                        state     <= TX_DATA;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        cycle_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            tx_o  <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            tx_o    <= shift_q[1];
                        end
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                default: begin
                    // Stop bit, line already high.
                    if (bit_end) begin
                        cycle_cnt <= '0;
                        state     <= TX_IDLE;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Payload shifter, bit 0 is the next bit on the line.
    always_ff @(posedge clk_i) begin
        if (state == TX_IDLE && in_valid_i) begin
            shift_q <= in_data_i;
        end else if (state == TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
/*
 * UART receiver.
 * Samples 8N1 frames at mid-bit and holds one byte until it is consumed.
 */

`default_nettype none

module uart_rx
    import uart_link_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  baud_div_t  baud_div_i,

    output uart_byte_t out_data_o,
    output logic       out_valid_o,
    input  logic       out_ready_i,

    input  logic       rx_i
);

    logic       rx_meta;
    logic       rx_sync;
    logic       rx_prev;
    logic       fall_edge;

    rx_state_t  state;
    baud_div_t  cycle_cnt;
    bit_idx_t   bit_idx;
    uart_byte_t shift_q;
    logic       half_end;
    logic       bit_end;

    // Line idles high, so the synchronizer resets to 1.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall_edge = rx_prev && !rx_sync;
    assign half_end  = (cycle_cnt == (baud_div_i >> 1) - 1'b1);
    assign bit_end   = (cycle_cnt == baud_div_i - 1'b1);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= RX_IDLE;
            cycle_cnt   <= '0;
            bit_idx     <= '0;
            out_data_o  <= '0;
            out_valid_o <= 1'b0;
        end else begin
            if (out_valid_o && out_ready_i) begin
                out_valid_o <= 1'b0;
            end

            case (state)
                RX_IDLE: begin
                    if (fall_edge) begin
                        cycle_cnt <= '0;
                        state     <= RX_START;
                    end
                end
                RX_START: begin
                    // Middle of the start bit, a glitch goes back to idle.
                    if (half_end) begin
                        cycle_cnt <= '0;
                        bit_idx   <= '0;
                        state     <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cycle_cnt <= '0;
                        bit_idx   <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        cycle_cnt <= '0;
                        // Frame dropped on a bad stop bit or while a byte is held.
                        if (rx_sync && !out_valid_o) begin
                            out_data_o  <= shift_q;
                            out_valid_o <= 1'b1;
                        end
                        state <= rx_sync ? RX_IDLE : RX_HOLD;
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                default: begin
                    if (rx_sync) begin
                        state <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB arrives first and ends up in bit 0 after eight shifts.
    always_ff @(posedge clk_i) begin
        if (state == RX_DATA && bit_end) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

endmodule

`default_nettype wire

//--- uart/uart_core.sv
/*
 * UART core with its register block.
 * Decodes the register bus and connects the transmit and receive engines.
 */

`default_nettype none

`include "uart_config.svh"

module uart_core
    import uart_reg_pkg::*;
    import uart_link_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       wr_en_i,
    input  uart_addr_t wr_addr_i,
    input  uart_word_t wr_data_i,
    input  uart_be_t   wr_byte_en_i,

    input  logic       rd_en_i,
    input  uart_addr_t rd_addr_i,
    output uart_word_t rd_data_o,

    input  logic       rx_i,
    output logic       tx_o
);

    uart_reg_t wr_sel;
    uart_reg_t rd_sel;
    logic      wr_hit;

    uart_ctrl_0_t ctrl_0;
    logic         soft_en;

    uart_byte_t tx_data;
    logic       tx_valid;
    logic       tx_ready;

    uart_byte_t rx_data;
    logic       rx_valid;
    logic       rx_ready;

    uart_ctrl_1_t  ctrl_1_view;
    uart_data_tx_t data_tx_view;
    uart_data_rx_t data_rx_view;
    uart_word_t    rd_word;

    assign wr_sel = uart_reg_t'(wr_addr_i[`UART_REG_MSB:`UART_REG_LSB]);
    assign rd_sel = uart_reg_t'(rd_addr_i[`UART_REG_MSB:`UART_REG_LSB]);

    // Any byte enable writes the whole register.
    assign wr_hit = wr_en_i && (|wr_byte_en_i);

    // Status words, reserved bits tied to 0.
    assign ctrl_1_view  = '{rsvd: '0, enable: soft_en};
    assign data_tx_view = '{rsvd: '0, tx_flag: tx_ready, tx_data: tx_data};
    assign data_rx_view = '{rsvd: '0, rx_flag: rx_valid, rx_data: rx_data};

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_0  <= '0;
            soft_en <= 1'b0;
        end else if (wr_hit) begin
            case (wr_sel)
                CTRL_0:  ctrl_0.baud <= wr_data_i;
                CTRL_1:  soft_en <= wr_data_i[0];
                default: ;
            endcase
        end
    end

    // Transmit holding register. A new write replaces a pending byte.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tx_data  <= '0;
            tx_valid <= 1'b0;
        end else if (wr_hit && (wr_sel == DATA_TX)) begin
            tx_data  <= wr_data_i[7:0];
            tx_valid <= 1'b1;
        end else if (tx_ready || !soft_en) begin
            tx_valid <= 1'b0;
        end
    end

    // Pop the received byte after a read that saw it valid.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rx_ready <= 1'b0;
        end else begin
            rx_ready <= rd_en_i && (rd_sel == DATA_RX) && rx_valid && !rx_ready;
        end
    end

    always_comb begin
        case (rd_sel)
            CTRL_0:  rd_word = ctrl_0;
            CTRL_1:  rd_word = ctrl_1_view;
            DATA_TX: rd_word = data_tx_view;
            default: rd_word = data_rx_view;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= rd_word;
        end
    end

    // Both engines are held in reset while the soft enable is low.
    uart_tx u_uart_tx (
        .clk_i      (clk_i),
        .rst_n_i    (soft_en),
        .baud_div_i (ctrl_0.baud),
        .in_data_i  (tx_data),
        .in_valid_i (tx_valid),
        .in_ready_o (tx_ready),
        .tx_o       (tx_o)
    );

    uart_rx u_uart_rx (
        .clk_i       (clk_i),
        .rst_n_i     (soft_en),
        .baud_div_i  (ctrl_0.baud),
        .out_data_o  (rx_data),
        .out_valid_o (rx_valid),
        .out_ready_i (rx_ready),
        .rx_i        (rx_i)
    );

endmodule

`default_nettype wire

//--- testbench/uart_checker.sv
/*
 * UART core checker.
 * Assertions on the engine handshakes and on the registered read port.
 */

`default_nettype none

module uart_checker
    import uart_reg_pkg::*;
(
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       soft_en_i,
    input logic       tx_line_i,
    input logic       tx_valid_i,
    input logic       tx_ready_i,
    input logic       rx_valid_i,
    input logic       rx_ready_i,
    input logic       rd_en_i,
    input uart_word_t rd_data_i
);

    // Held engines keep the line idle.
    tx_idle_when_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !soft_en_i |-> tx_line_i)
        else $error("tx_o is low while the engines are held in reset");

    tx_valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i || !soft_en_i)
        tx_valid_i && !tx_ready_i |=> tx_valid_i)
        else $error("tx_valid dropped before tx_ready");

    rx_pop_with_data: assert property (@(posedge clk_i) disable iff (!rst_n_i || !soft_en_i)
        rx_ready_i |-> rx_valid_i)
        else $error("rx_ready is high without rx_valid");

    // Read data only moves the cycle after a read.
    rd_data_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !rd_en_i |=> $stable(rd_data_i))
        else $error("rd_data_o changed without a read");

endmodule

bind uart_core uart_checker u_uart_checker (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .soft_en_i  (soft_en),
    .tx_line_i  (tx_o),
    .tx_valid_i (tx_valid),
    .tx_ready_i (tx_ready),
    .rx_valid_i (rx_valid),
    .rx_ready_i (rx_ready),
    .rd_en_i    (rd_en_i),
    .rd_data_i  (rd_data_o)
);

`default_nettype wire

//--- testbench/uart_tb.sv
/*
 * UART core testbench.
 * Directed tests of the registers, transmit, receive, loopback and soft reset.
 */

`default_nettype none

`include "uart_config.svh"

module uart_tb
    import uart_reg_pkg::*;
    import uart_link_pkg::*;
();

    localparam int BAUD_DIV         = 16;
    localparam int FRAME_BITS       = 10;
    localparam int NUM_FRAMES       = 14;
    localparam int TIMEOUT_CYCLES   = NUM_FRAMES * FRAME_BITS * BAUD_DIV * 2 + 2000;
    localparam int RX_POLL_LIMIT    = 150;
    localparam int TX_POLL_LIMIT    = 20;
    localparam int START_WAIT_LIMIT = 400;

    logic       clk;
    logic       rst_n;
    logic       wr_en;
    uart_addr_t wr_addr;
    uart_word_t wr_data;
    uart_be_t   wr_be;
    logic       rd_en;
    uart_addr_t rd_addr;
    uart_word_t rd_data;
    logic       rx_line;
    logic       tx_line;
    logic       rx_drv;
    logic       loopback_en;

    int mismatch_count;
    int missing_count;
    int cycle_count;

    assign rx_line = loopback_en ? tx_line : rx_drv;

    uart_core UUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .wr_en_i      (wr_en),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .wr_byte_en_i (wr_be),
        .rd_en_i      (rd_en),
        .rd_addr_i    (rd_addr),
        .rd_data_o    (rd_data),
        .rx_i         (rx_line),
        .tx_o         (tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic uart_addr_t reg_addr(input uart_reg_t sel);
        uart_addr_t addr;
        addr = '0;
        addr[`UART_REG_MSB:`UART_REG_LSB] = sel;
        return addr;
    endfunction

    // 8N1 frame, bit 0 goes on the line first.
    function automatic logic [9:0] frame_bits(input uart_byte_t value);
        return {1'b1, value, 1'b0};
    endfunction

    task automatic report_mismatch(input string name, input uart_word_t expected,
                                   input uart_word_t actual);
        mismatch_count++;
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic report_missing(input string what);
        missing_count++;
        $display("ERROR: %s", what);
    endtask

    task automatic bus_write(input uart_reg_t sel, input uart_word_t data, input uart_be_t be);
        @(posedge clk);
        wr_en   <= 1'b1;
        wr_addr <= reg_addr(sel);
        wr_data <= data;
        wr_be   <= be;
        @(posedge clk);
        wr_en <= 1'b0;
        wr_be <= '0;
    endtask

    task automatic bus_read(input uart_reg_t sel, output uart_word_t data);
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= reg_addr(sel);
        @(posedge clk);
        rd_en <= 1'b0;
        @(negedge clk);
        data = rd_data;
    endtask

    task automatic send_frame(input uart_byte_t value);
        logic [9:0] frame;
        frame = frame_bits(value);
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(posedge clk);
            rx_drv <= frame[i];
            repeat (BAUD_DIV - 1) @(posedge clk);
        end
    endtask

    task automatic capture_frame(output logic [9:0] bits, output logic found);
        int waited;
        waited = 0;
        bits   = '1;
        @(negedge clk);
        while (tx_line !== 1'b0 && waited < START_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        found = (tx_line === 1'b0);
        if (found) begin
            // First low sample is half a cycle into the start bit.
            repeat (BAUD_DIV / 2 - 1) @(negedge clk);
            for (int i = 0; i < FRAME_BITS; i++) begin
                bits[i] = tx_line;
                if (i < FRAME_BITS - 1) begin
                    repeat (BAUD_DIV) @(negedge clk);
                end
            end
        end
    endtask

    task automatic poll_rx(input string name, output uart_word_t word);
        uart_data_rx_t rx_view;
        int            polls;
        polls = 0;
        bus_read(DATA_RX, word);
        rx_view = word;
        while (!rx_view.rx_flag && polls < RX_POLL_LIMIT) begin
            bus_read(DATA_RX, word);
            rx_view = word;
            polls++;
        end
        if (!rx_view.rx_flag) begin
            report_missing({name, ": DATA_RX never reported a received byte"});
        end
    endtask

    task automatic poll_tx_idle(output uart_word_t word);
        uart_data_tx_t tx_view;
        int            polls;
        polls = 0;
        bus_read(DATA_TX, word);
        tx_view = word;
        while (!tx_view.tx_flag && polls < TX_POLL_LIMIT) begin
            bus_read(DATA_TX, word);
            tx_view = word;
            polls++;
        end
    endtask

    task automatic check_frame(input string name, input uart_byte_t value);
        logic [9:0] bits;
        logic       found;
        capture_frame(bits, found);
        if (!found) begin
            report_missing({name, ": no start bit appeared on tx_o"});
        end else if (bits !== frame_bits(value)) begin
            report_mismatch(name, {22'h0, frame_bits(value)}, {22'h0, bits});
        end
    endtask

    task automatic test_reset();
        uart_word_t word;
        bus_read(CTRL_0, word);
        if (word !== 32'h0) report_mismatch("reset CTRL_0", 32'h0, word);
        bus_read(CTRL_1, word);
        if (word !== 32'h0) report_mismatch("reset CTRL_1", 32'h0, word);
        // Held engines report neither ready nor valid.
        bus_read(DATA_TX, word);
        if (word !== 32'h0) report_mismatch("reset DATA_TX", 32'h0, word);
        bus_read(DATA_RX, word);
        if (word !== 32'h0) report_mismatch("reset DATA_RX", 32'h0, word);
        if (tx_line !== 1'b1) report_mismatch("reset tx_o", 32'h1, {31'h0, tx_line});
    endtask

    task automatic test_registers();
        uart_word_t word;
        uart_word_t value;
        value = $urandom();
        bus_write(CTRL_0, value, 4'hF);
        bus_read(CTRL_0, word);
        if (word !== value) report_mismatch("registers CTRL_0", value, word);
        bus_write(CTRL_0, ~value, 4'h0);
        bus_read(CTRL_0, word);
        if (word !== value) report_mismatch("registers no byte enable", value, word);
        bus_write(DATA_RX, 32'h1FF, 4'hF);
        bus_read(DATA_RX, word);
        if (word !== 32'h0) report_mismatch("registers DATA_RX write", 32'h0, word);
        bus_write(CTRL_0, BAUD_DIV, 4'hF);
        bus_read(CTRL_0, word);
        if (word !== BAUD_DIV) report_mismatch("registers baud", BAUD_DIV, word);
        bus_write(CTRL_1, 32'hFFFF_FFFF, 4'hF);
        bus_read(CTRL_1, word);
        if (word !== 32'h1) report_mismatch("registers CTRL_1", 32'h1, word);
        bus_write(CTRL_1, 32'h0, 4'h1);
        bus_read(CTRL_1, word);
        if (word !== 32'h0) report_mismatch("registers CTRL_1 clear", 32'h0, word);
    endtask

    task automatic test_transmit();
        uart_byte_t    value;
        uart_word_t    mid_word;
        uart_word_t    word;
        uart_data_tx_t exp_tx;
        value = uart_byte_t'($urandom());
        bus_write(CTRL_1, 32'h1, 4'hF);
        bus_write(DATA_TX, {24'h0, value}, 4'hF);
        fork
            check_frame("transmit frame", value);
            begin
                repeat (4 * BAUD_DIV) @(posedge clk);
                bus_read(DATA_TX, mid_word);
            end
        join
        exp_tx = '{rsvd: '0, tx_flag: 1'b0, tx_data: value};
        if (mid_word !== exp_tx) report_mismatch("transmit busy flag", exp_tx, mid_word);
        poll_tx_idle(word);
        exp_tx.tx_flag = 1'b1;
        if (word !== exp_tx) report_mismatch("transmit idle flag", exp_tx, word);
    endtask

    task automatic test_receive();
        uart_byte_t    first;
        uart_byte_t    second;
        uart_word_t    word;
        uart_data_rx_t exp_rx;
        first  = uart_byte_t'($urandom());
        second = uart_byte_t'($urandom());
        send_frame(first);
        poll_rx("receive", word);
        exp_rx = '{rsvd: '0, rx_flag: 1'b1, rx_data: first};
        if (word !== exp_rx) report_mismatch("receive byte", exp_rx, word);
        bus_read(DATA_RX, word);
        if (word[8] !== 1'b0) report_mismatch("receive consumed", 32'h0, {31'h0, word[8]});
        // The frame after second arrives while second is still held.
        send_frame(second);
        send_frame(~second);
        poll_rx("receive overrun", word);
        exp_rx = '{rsvd: '0, rx_flag: 1'b1, rx_data: second};
        if (word !== exp_rx) report_mismatch("receive overrun", exp_rx, word);
        bus_read(DATA_RX, word);
        exp_rx.rx_flag = 1'b0;
        if (word !== exp_rx) report_mismatch("receive dropped frame", exp_rx, word);
    endtask

    task automatic test_loopback();
        uart_byte_t    value;
        uart_word_t    word;
        uart_data_rx_t rx_view;
        @(posedge clk);
        loopback_en <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            value = uart_byte_t'($urandom());
            bus_write(DATA_TX, {24'h0, value}, 4'hF);
            poll_rx("loopback", word);
            rx_view = word;
            if (rx_view.rx_data !== value) begin
                report_mismatch("loopback byte", {24'h0, value}, {24'h0, rx_view.rx_data});
            end
        end
        @(posedge clk);
        loopback_en <= 1'b0;
    endtask

    task automatic test_soft_reset();
        uart_byte_t    value;
        uart_word_t    word;
        uart_data_tx_t exp_tx;
        int            waited;
        int            low_seen;
        // Data bits 1 to 3 are low, so the line is low where the frame is cut.
        value = uart_byte_t'($urandom()) & 8'hF1;
        waited = 0;
        low_seen = 0;
        bus_write(DATA_TX, {24'h0, value}, 4'hF);
        while (tx_line !== 1'b0 && waited < START_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (tx_line !== 1'b0) report_missing("soft reset: frame never started on tx_o");
        repeat (3 * BAUD_DIV + 4) @(posedge clk);
        bus_write(CTRL_1, 32'h0, 4'hF);
        @(negedge clk);
        if (tx_line !== 1'b1) report_mismatch("soft reset tx_o", 32'h1, {31'h0, tx_line});
        bus_read(DATA_TX, word);
        exp_tx = '{rsvd: '0, tx_flag: 1'b0, tx_data: value};
        if (word !== exp_tx) report_mismatch("soft reset DATA_TX", exp_tx, word);
        repeat (FRAME_BITS * BAUD_DIV) begin
            @(negedge clk);
            if (tx_line !== 1'b1) low_seen++;
        end
        if (low_seen != 0) report_missing("soft reset: tx_o went low while held");
        bus_write(CTRL_1, 32'h1, 4'hF);
        value = uart_byte_t'($urandom());
        bus_write(DATA_TX, {24'h0, value}, 4'hF);
        check_frame("soft reset recovery", value);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hb967_6dbc));
        mismatch_count = 0;
        missing_count  = 0;
        rst_n       <= 1'b0;
        wr_en       <= 1'b0;
        wr_addr     <= '0;
        wr_data     <= '0;
        wr_be       <= '0;
        rd_en       <= 1'b0;
        rd_addr     <= '0;
        rx_drv      <= 1'b1;
        loopback_en <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_reset();
        test_registers();
        test_transmit();
        test_receive();
        test_loopback();
        test_soft_reset();
        $display("Mismatches: %0d, missing responses: %0d", mismatch_count, missing_count);
        if (mismatch_count == 0 && missing_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+common
common/uart_reg_pkg.sv
common/uart_link_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_core.sv
testbench/uart_checker.sv
testbench/uart_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the UART testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module uart_tb -o uart_tb_sim

sim_output=$(./obj_dir/uart_tb_sim)
echo "$sim_output"

if echo "$sim_output" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
